// File: Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - files:
      - design/mips_pkg.sv
      - design/mips_decoder.sv
      - design/mips_regfile.sv
      - design/mips_alu.sv
      - design/mips_next_pc.sv
      - design/mips_cpu_harvard.sv
  - target: test
    files:
      - tb/mips_chk.sv
      - tb/mips_scoreboard.sv
      - tb/mips_tb.sv

// File: design/mips_alu.sv
`timescale 1ns/10ps

module mips_alu
  import mips_pkg::*;
(
  input  alu_op_t     alu_op,
  input  logic        alu_src,
  input  logic        zero_ext,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [15:0] imm,
  input  logic [4:0]  shamt,
  output logic [31:0] result,
  output logic        equal
);

  logic [31:0] imm_ext;
  logic [31:0] op_b;

  // andi and ori take the zero extended form
  assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

  // second operand is rt or the immediate
  assign op_b = alu_src ? imm_ext : b;

  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + op_b;
      ALU_SUB: result = a - op_b;
      ALU_AND: result = a & op_b;
      ALU_OR:  result = a | op_b;
      ALU_XOR: result = a ^ op_b;
      ALU_SLT: begin
        // signed compare
        result = {31'b0, $signed(a) < $signed(op_b)};
      end
      // shifts act on rt by shamt
      ALU_SLL: result = op_b << shamt;
      ALU_SRL: result = op_b >> shamt;
      ALU_LUI: result = {imm, 16'h0000};
      default: result = '0;
    endcase
  end

  // branch compare uses the raw register values
  assign equal = (a == b);

endmodule

// File: design/mips_cpu_harvard.sv
`timescale 1ns/10ps

module mips_cpu_harvard
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  cpu_state_t  state;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic        advance;

  // instruction fields
  opcode_t     opcode;
  funct_t      funct;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;

  // decoder levels
  alu_op_t     alu_op;
  logic        alu_src;
  logic        zero_ext;
  logic        reg_dst_rd;
  logic        reg_write;
  logic        mem_read;
  logic        mem_write;
  logic        mem_to_reg;
  logic        link;
  logic        branch_eq;
  logic        branch_ne;
  logic        jump_imm;
  logic        jump_reg;

  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_result;
  logic        equal;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  assign opcode = opcode_t'(instr_readdata[31:26]);
  assign funct  = funct_t'(instr_readdata[5:0]);
  assign rs     = instr_readdata[25:21];
  assign rt     = instr_readdata[20:16];
  assign rd     = instr_readdata[15:11];

  // an instruction retires only on this condition
  assign advance = clk_enable && (state == EXEC) && (pc != halt_address);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXEC;
      pc    <= reset_vector;
    end else if (clk_enable && state == EXEC) begin
      if (pc == halt_address) begin
        state <= HALTED;
      end else begin
        pc <= next_pc;
      end
    end
  end

  assign active = (state == EXEC);

  mips_decoder u_mips_decoder (
    .opcode     (opcode),
    .funct      (funct),
    .alu_op     (alu_op),
    .alu_src    (alu_src),
    .zero_ext   (zero_ext),
    .reg_dst_rd (reg_dst_rd),
    .reg_write  (reg_write),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_to_reg (mem_to_reg),
    .link       (link),
    .branch_eq  (branch_eq),
    .branch_ne  (branch_ne),
    .jump_imm   (jump_imm),
    .jump_reg   (jump_reg)
  );

  // jal links to r31, r-type writes rd, the rest write rt
  assign wb_addr = link ? link_reg : (reg_dst_rd ? rd : rt);

  // link value skips the delay slot
  assign wb_data = mem_to_reg ? data_readdata
                 : link ? pc + 32'd8
                 : alu_result;

  mips_regfile u_mips_regfile (
    .clk          (clk),
    .reset        (reset),
    .clk_enable   (clk_enable),
    .rs_addr      (rs),
    .rt_addr      (rt),
    .rd_addr      (wb_addr),
    .rd_data      (wb_data),
    .write_enable (reg_write && advance),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .register_v0  (register_v0)
  );

  mips_alu u_mips_alu (
    .alu_op   (alu_op),
    .alu_src  (alu_src),
    .zero_ext (zero_ext),
    .a        (rs_data),
    .b        (rt_data),
    .imm      (instr_readdata[15:0]),
    .shamt    (instr_readdata[10:6]),
    .result   (alu_result),
    .equal    (equal)
  );

  mips_next_pc u_mips_next_pc (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .pc        (pc),
    .rs_data   (rs_data),
    .equal     (equal),
    .imm       (instr_readdata[15:0]),
    .target    (instr_readdata[25:0]),
    .branch_eq (branch_eq),
    .branch_ne (branch_ne),
    .jump_imm  (jump_imm),
    .jump_reg  (jump_reg),
    .next_pc   (next_pc)
  );

  assign instr_address  = pc;
  assign data_address   = alu_result;
  assign data_writedata = rt_data;

  // strobes only while an instruction retires
  assign data_write = mem_write && advance;
  assign data_read  = mem_read && advance;

endmodule

// File: design/mips_decoder.sv
`timescale 1ns/10ps

module mips_decoder
  import mips_pkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output alu_op_t alu_op,
  output logic    alu_src,
  output logic    zero_ext,
  output logic    reg_dst_rd,
  output logic    reg_write,
  output logic    mem_read,
  output logic    mem_write,
  output logic    mem_to_reg,
  output logic    link,
  output logic    branch_eq,
  output logic    branch_ne,
  output logic    jump_imm,
  output logic    jump_reg
);

  always_comb begin
    // unknown encodings fall through as a nop
    alu_op     = ALU_ADD;
    alu_src    = 1'b0;
    zero_ext   = 1'b0;
    reg_dst_rd = 1'b0;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    link       = 1'b0;
    branch_eq  = 1'b0;
    branch_ne  = 1'b0;
    jump_imm   = 1'b0;
    jump_reg   = 1'b0;

    case (opcode)
      OP_SPECIAL: begin
        // r-type, result goes to rd
        reg_dst_rd = 1'b1;
        reg_write  = 1'b1;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_JR: begin
            reg_write = 1'b0;
            jump_reg  = 1'b1;
          end
          default: begin
            reg_dst_rd = 1'b0;
            reg_write  = 1'b0;
          end
        endcase
      end
      OP_J: jump_imm = 1'b1;
      OP_JAL: begin
        jump_imm  = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1;
      end
      OP_BEQ: branch_eq = 1'b1;
      OP_BNE: branch_ne = 1'b1;
      OP_ADDIU: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_ANDI: begin
        alu_op    = ALU_AND;
        alu_src   = 1'b1;
        zero_ext  = 1'b1;
        reg_write = 1'b1;
      end
      OP_ORI: begin
        alu_op    = ALU_OR;
        alu_src   = 1'b1;
        zero_ext  = 1'b1;
        reg_write = 1'b1;
      end
      OP_LUI: begin
        alu_op    = ALU_LUI;
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LW: begin
        // address is base plus signed offset
        alu_src    = 1'b1;
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
      end
      OP_SW: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: design/mips_next_pc.sv
`timescale 1ns/10ps

module mips_next_pc (
  input  logic        clk,
  input  logic        reset,
  input  logic        advance,
  input  logic [31:0] pc,
  input  logic [31:0] rs_data,
  input  logic        equal,
  input  logic [15:0] imm,
  input  logic [25:0] target,
  input  logic        branch_eq,
  input  logic        branch_ne,
  input  logic        jump_imm,
  input  logic        jump_reg,
  output logic [31:0] next_pc
);

  logic [31:0] pc_plus4;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] chosen_target;
  logic        taken;

  // delay slot state
  logic        delay_flag;
  logic [31:0] delay_target;

  assign pc_plus4 = pc + 32'd4;

  // offset is relative to the delay slot address
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

  // region bits come from the delay slot address
  assign jump_target = {pc_plus4[31:28], target, 2'b00};

  assign taken = (branch_eq && equal)
               || (branch_ne && !equal)
               || jump_imm
               || jump_reg;

  always_comb begin
    if (jump_reg) begin
      chosen_target = rs_data;
    end else if (jump_imm) begin
      chosen_target = jump_target;
    end else begin
      chosen_target = branch_target;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      delay_flag <= 1'b0;
    end else if (advance) begin
      delay_flag <= taken;
    end
  end

  // held for one instruction, the slot
  always_ff @(posedge clk) begin
    if (advance) begin
      delay_target <= chosen_target;
    end
  end

  assign next_pc = delay_flag ? delay_target : pc_plus4;

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000,
    OP_J       = 6'b000010,
    OP_JAL     = 6'b000011,
    OP_BEQ     = 6'b000100,
    OP_BNE     = 6'b000101,
    OP_ADDIU   = 6'b001001,
    OP_ANDI    = 6'b001100,
    OP_ORI     = 6'b001101,
    OP_LUI     = 6'b001111,
    OP_LW      = 6'b100011,
    OP_SW      = 6'b101011
  } opcode_t;

  // function codes under OP_SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_SLT  = 6'b101010
  } funct_t;

  // internal alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_t;

  typedef enum logic {
    EXEC    = 1'b0,
    HALTED  = 1'b1
  } cpu_state_t;

  localparam logic [31:0] reset_vector = 32'hBFC00000;
  // fetching here stops the core
  localparam logic [31:0] halt_address = 32'h00000000;
  localparam logic [4:0] link_reg = 5'd31;
  localparam logic [4:0] v0_reg = 5'd2;

endpackage

// File: design/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic        write_enable,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (clk_enable && write_enable && rd_addr != 5'd0) begin
      // r0 is never written so it reads back as zero
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational read ports
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  assign register_v0 = regs[v0_reg];

endmodule

// File: sim.f
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_next_pc.sv
design/mips_cpu_harvard.sv
tb/mips_chk.sv
tb/mips_scoreboard.sv
tb/mips_tb.sv

// File: tb/mips_chk.sv
`timescale 1ns/10ps

module mips_chk
  import mips_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic clk_enable,
  input logic active,
  input logic data_write,
  input logic data_read
);

  int fail_count = 0;

  a_strobes_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(data_write && data_read)
  ) else begin
    fail_count++;
    $error("data_write and data_read high together");
  end

  // no memory write while stalled or halted
  a_write_gated: assert property (
    @(posedge clk) disable iff (reset) (!clk_enable || !active) |-> !data_write
  ) else begin
    fail_count++;
    $error("data_write high with clk_enable or active low");
  end

  a_stays_halted: assert property (
    @(posedge clk) disable iff (reset) !active |=> !active
  ) else begin
    fail_count++;
    $error("active rose again without reset");
  end

endmodule

bind mips_cpu_harvard mips_chk u_mips_chk (
  .clk        (clk),
  .reset      (reset),
  .clk_enable (clk_enable),
  .active     (active),
  .data_write (data_write),
  .data_read  (data_read)
);

// File: tb/mips_scoreboard.sv
`timescale 1ns/10ps

module mips_scoreboard
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic        active,
  input  logic [31:0] register_v0,
  input  logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  input  logic [31:0] data_address,
  input  logic        data_write,
  input  logic        data_read,
  input  logic [31:0] data_writedata,
  input  logic        run_done,
  input  int          program_length,
  output int          error_count,
  output int          check_count
);

  // isa model state
  logic [31:0] mregs [32];
  logic [31:0] mmem [16];
  logic [31:0] mpc;
  logic        m_active;
  logic        m_delay;
  logic [31:0] m_target;
  logic        after_reset;
  int          retired;
  int          skipped;
  int          test_errors [1:6];

  initial begin
    error_count = 0;
    check_count = 0;
    after_reset = 1'b0;
    for (int i = 1; i <= 6; i++) begin
      test_errors[i] = 0;
    end
  end

  function automatic logic [31:0] initial_word(input int i);
    return 32'h3C000000 + i * 32'h00110011;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act,
                         input int test);
    check_count++;
    if (act !== exp) begin
      error_count++;
      test_errors[test]++;
      $display("** Error: %s expected 0x%h got 0x%h (test %0d at %0t)",
               name, exp, act, test, $time);
    end
  endtask

  task automatic print_result(input int n, input string name);
    $display("test %0d %s: %0d errors", n, name, test_errors[n]);
  endtask

  always @(posedge clk) begin
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [15:0] imm;
    logic [31:0] rsv;
    logic [31:0] rtv;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] pc4;
    logic [31:0] res;
    logic [31:0] tgt;
    logic [31:0] nxt;
    logic        run;
    logic        wr;
    logic        taken;
    int          tn;
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        mregs[i] = '0;
      end
      for (int i = 0; i < 16; i++) begin
        mmem[i] = initial_word(i);
      end
      mpc = reset_vector;
      m_active = 1'b1;
      m_delay = 1'b0;
      m_target = '0;
      retired = 0;
      skipped = 0;
      after_reset = 1'b1;
    end else begin
      op = instr_readdata[31:26];
      fn = instr_readdata[5:0];
      rs = instr_readdata[25:21];
      rt = instr_readdata[20:16];
      imm = instr_readdata[15:0];
      rsv = mregs[rs];
      rtv = mregs[rt];
      simm = {{16{imm[15]}}, imm};
      addr = rsv + simm;
      pc4 = mpc + 32'd4;
      run = clk_enable && m_active && mpc != halt_address;
      if (after_reset) begin
        compare("active", 32'd1, {31'b0, active}, 1);
        compare("instr_address", reset_vector, instr_address, 1);
        compare("data_write", 32'd0, {31'b0, data_write}, 1);
        print_result(1, "reset state");
        after_reset = 1'b0;
      end
      // halted, stalled or running
      tn = !m_active ? 6 : (!clk_enable ? 5 : 2);
      compare("active", {31'b0, m_active}, {31'b0, active}, tn);
      compare("instr_address", mpc, instr_address, tn);
      compare("register_v0", mregs[2], register_v0, tn == 2 ? 4 : tn);
      compare("data_write", {31'b0, run && op == OP_SW}, {31'b0, data_write}, tn == 2 ? 3 : tn);
      compare("data_read", {31'b0, run && op == OP_LW}, {31'b0, data_read}, tn == 2 ? 3 : tn);
      if (run && op == OP_SW) begin
        compare("data_address", addr, data_address, 3);
        compare("data_writedata", rtv, data_writedata, 3);
      end
      if (clk_enable && m_active && mpc == halt_address) begin
        m_active = 1'b0;
      end else if (run) begin
        wr = 1'b1;
        dest = rt;
        res = '0;
        taken = 1'b0;
        tgt = '0;
        case (op)
          OP_SPECIAL: begin
            dest = instr_readdata[15:11];
            case (fn)
              FN_SLL: res = rtv << instr_readdata[10:6];
              FN_SRL: res = rtv >> instr_readdata[10:6];
              FN_ADDU: res = rsv + rtv;
              FN_SUBU: res = rsv - rtv;
              FN_AND: res = rsv & rtv;
              FN_OR: res = rsv | rtv;
              FN_XOR: res = rsv ^ rtv;
              FN_SLT: res = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
              FN_JR: begin
                wr = 1'b0;
                taken = 1'b1;
                tgt = rsv;
              end
              default: wr = 1'b0;
            endcase
          end
          OP_J, OP_JAL: begin
            taken = 1'b1;
            tgt = {pc4[31:28], instr_readdata[25:0], 2'b00};
            wr = (op == OP_JAL);
            dest = 5'd31;
            res = mpc + 32'd8;
          end
          OP_BEQ, OP_BNE: begin
            wr = 1'b0;
            taken = (op == OP_BEQ) ? (rsv == rtv) : (rsv != rtv);
            tgt = pc4 + (simm << 2);
          end
          OP_ADDIU: res = rsv + simm;
          OP_ANDI: res = rsv & {16'h0000, imm};
          OP_ORI: res = rsv | {16'h0000, imm};
          OP_LUI: res = {imm, 16'h0000};
          OP_LW: res = mmem[addr[5:2]];
          OP_SW: begin
            wr = 1'b0;
            mmem[addr[5:2]] = rtv;
          end
          default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
          mregs[dest] = res;
        end
        nxt = m_delay ? m_target : pc4;
        // forward transfers step over the words between slot and target
        if (nxt != halt_address && nxt > pc4) begin
          skipped += (nxt - pc4) >> 2;
        end
        m_delay = taken;
        m_target = tgt;
        mpc = nxt;
        retired++;
      end
    end
  end

  always @(posedge run_done) begin
    print_result(2, "program counter flow");
    print_result(3, "data strobes");
    print_result(4, "register v0");
    print_result(5, "stall hold");
    compare("retired plus skipped words", program_length, retired + skipped, 6);
    compare("model active", 32'd0, {31'b0, m_active}, 6);
    print_result(6, "halt");
  end

endmodule

// File: tb/mips_tb.sv
`timescale 1ns/10ps

module mips_tb
  import mips_pkg::*;
();

  localparam int prog_len = 300;
  localparam int cycle_limit = 4 * prog_len;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic        data_write;
  logic        data_read;
  logic        run_done;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  logic [31:0] word_index;
  logic [31:0] prog [prog_len];
  logic [31:0] dmem [16];
  int          sb_errors;
  int          sb_checks;
  int          cycles;
  int          total_errors;

  mips_cpu_harvard u_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  mips_scoreboard u_mips_scoreboard (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .run_done       (run_done),
    .program_length (prog_len),
    .error_count    (sb_errors),
    .check_count    (sb_checks)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // program memory starts at the reset vector with zero words elsewhere
  assign word_index = (instr_address - reset_vector) >> 2;
  assign instr_readdata = (word_index < prog_len) ? prog[word_index] : 32'h0;

  assign data_readdata = dmem[data_address[5:2]];

  always @(posedge clk) begin
    if (data_write) begin
      dmem[data_address[5:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] initial_word(input int i);
    return 32'h3C000000 + i * 32'h00110011;
  endfunction

  function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
    return {6'b000000, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'(1 + $urandom % 7);
  endfunction

  function automatic logic [5:0] pick_funct();
    logic [5:0] fns [8] = '{FN_SLL, FN_SRL, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    return fns[$urandom % 8];
  endfunction

  task automatic build_program();
    bit          in_slot;
    int          sel;
    int          k;
    logic [31:0] tgt;
    logic [4:0]  src;
    logic [4:0]  dst;
    in_slot = 1'b0;
    for (int i = 0; i < prog_len - 2; i++) begin
      sel = $urandom % 20;
      k = 2 + $urandom % 3;
      // r31 now and then so the jal link value reaches v0
      src = ($urandom % 8 == 0) ? 5'd31 : pick_reg();
      // r0 now and then as a destination, later r0 reads must still see zero
      dst = ($urandom % 8 == 0) ? 5'd0 : pick_reg();
      // no transfer in a delay slot or near the end
      if (sel < 4 && (in_slot || i > prog_len - 10)) begin
        sel = 8;
      end
      tgt = reset_vector + 32'((i + 1 + k) * 4);
      case (sel)
        0: prog[i] = i_type(OP_BEQ, pick_reg(), pick_reg(), 16'(k));
        1: prog[i] = i_type(OP_BNE, pick_reg(), pick_reg(), 16'(k));
        2: prog[i] = {OP_J, tgt[27:2]};
        3: prog[i] = {OP_JAL, tgt[27:2]};
        4, 5: prog[i] = i_type(OP_LW, 5'd0, pick_reg(), 16'(($urandom % 16) * 4));
        6, 7: prog[i] = i_type(OP_SW, 5'd0, pick_reg(), 16'(($urandom % 16) * 4));
        8, 9: prog[i] = i_type(OP_ADDIU, src, dst, 16'($urandom));
        10: prog[i] = i_type(OP_ANDI, src, pick_reg(), 16'($urandom));
        11: prog[i] = i_type(OP_ORI, src, pick_reg(), 16'($urandom));
        12: prog[i] = i_type(OP_LUI, 5'd0, pick_reg(), 16'($urandom));
        default: prog[i] = r_type(src, pick_reg(), dst, 5'($urandom), pick_funct());
      endcase
      in_slot = (sel < 4);
    end
    // jr through r0 lands on the halt address after the slot
    prog[prog_len - 2] = r_type(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
    prog[prog_len - 1] = 32'h0;
  endtask

  initial begin
    void'($urandom(32'h5d63b4de));
    reset = 1'b1;
    clk_enable = 1'b0;
    run_done = 1'b0;
    for (int i = 0; i < 16; i++) begin
      dmem[i] = initial_word(i);
    end
    build_program();
    repeat (2) @(posedge clk);
    // first cycle out of reset keeps the clock disabled
    @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (active && cycles < cycle_limit) begin
      @(negedge clk);
      clk_enable = ($urandom % 4) != 0;
      cycles++;
    end
    if (active) begin
      $display("timeout: core still running after %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end else begin
      // a few more cycles to watch the halted core
      repeat (8) begin
        @(negedge clk);
        clk_enable = ($urandom % 4) != 0;
      end
      run_done = 1'b1;
      @(negedge clk);
      total_errors = sb_errors + u_mips_cpu_harvard.u_mips_chk.fail_count;
      $display("checks: %0d  errors: %0d  assertion failures: %0d", sb_checks, sb_errors,
               u_mips_cpu_harvard.u_mips_chk.fail_count);
      if (total_errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule
